// ==== ternary_defs.svh ====
/*
 * sizing macros for the ternary accumulator
 * block length, grid shape, data widths and readout bit window
 */
`ifndef TERNARY_DEFS_SVH
`define TERNARY_DEFS_SVH

// beats per block, also the number of accumulator columns
`define SLICES 2
// base-3 digits held by one packed byte
`define TRITS_PER_BYTE 5
`define ROWS (`TRITS_PER_BYTE * `SLICES)
`define ACC_W 17
`define ACT_W 8
// low accumulator bits dropped at the output
`define OUT_SHIFT 8
// 3^5 - 1, every code above holds no weights
`define MAX_PACKED 242
// column index width
`define COL_W ((`SLICES > 1) ? $clog2(`SLICES) : 1)

`endif

// ==== ternary_pkg.sv ====
/*
 * shared types of the ternary accumulator
 * trits, packed trit groups, accumulator and activation values, readout states
 */
`include "ternary_defs.svh"

package ternary_pkg;

    // one ternary weight, encoded as its base-3 digit value
    typedef enum logic [1:0] {
        TRIT_ZERO = 2'd0,
        TRIT_POS  = 2'd1,
        TRIT_NEG  = 2'd2
    } trit_t;

    // the weights of one packed byte, element k is base-3 digit k
    typedef trit_t [`TRITS_PER_BYTE-1:0] trit_vec_t;

    // accumulator cell, wraps at ACC_W bits
    typedef logic signed [`ACC_W-1:0] acc_t;

    // signed activation sample
    typedef logic signed [`ACT_W-1:0] act_t;

    // readout queue states
    typedef enum logic {
        RD_IDLE,
        RD_STREAM
    } rd_state_t;

endpackage

// ==== ternary_unpack.sv ====
/*
 * base-3 weight decoder
 * splits one packed byte into five ternary weights
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module ternary_unpack (
    input  logic [7:0]             weight_byte,
    output ternary_pkg::trit_vec_t trits
);

    logic out_of_range;

    // codes past 3^5 - 1 carry no weights
    assign out_of_range = int'(weight_byte) > `MAX_PACKED;

    always_comb begin
        logic [7:0] rest;
        logic [1:0] digit;
        rest = weight_byte;
        // peel off the least significant base-3 digit each step
        for (int k = 0; k < `TRITS_PER_BYTE; k++) begin
            digit = 2'(rest % 8'd3);
            rest = rest / 8'd3;
            if (out_of_range) begin
                trits[k] = ternary_pkg::TRIT_ZERO;
            end else begin
                // digit 2 stands for -1
                case (digit)
                    2'd1: begin
                        trits[k] = ternary_pkg::TRIT_POS;
                    end
                    2'd2: begin
                        trits[k] = ternary_pkg::TRIT_NEG;
                    end
                    default: begin
                        trits[k] = ternary_pkg::TRIT_ZERO;
                    end
                endcase
            end
        end
    end

endmodule

// ==== operand_buffer.sv ====
/*
 * double-buffered operand store
 * collects beats into staging, swaps complete blocks to current
 * and walks the activation columns one per cycle
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module operand_buffer (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                load,
    input  logic                                read_out,
    input  ternary_pkg::trit_vec_t              trits,
    input  ternary_pkg::act_t                   activation,
    output ternary_pkg::trit_t [`ROWS-1:0]      row_trits,
    output ternary_pkg::act_t                   col_act,
    output logic [`COL_W-1:0]                   col_index,
    output logic                                mac_en,
    output logic                                busy
);

    // staging side, filled beat by beat
    ternary_pkg::trit_vec_t stage_trits [`SLICES];
    ternary_pkg::act_t      stage_act   [`SLICES];
    // current side, held steady during the walk
    ternary_pkg::trit_vec_t cur_trits [`SLICES];
    ternary_pkg::act_t      cur_act   [`SLICES];

    logic [`COL_W-1:0] slice_cnt;
    logic [`COL_W-1:0] col_cnt;
    logic              walk_active;
    logic              take_beat;
    logic              block_done;
    logic              last_col;

    // a readout drops any beat offered in the same cycle
    assign take_beat  = load && !read_out;
    assign block_done = take_beat && (int'(slice_cnt) == `SLICES - 1);
    assign last_col   = int'(col_cnt) == `SLICES - 1;

    always_ff @(posedge clk) begin
        if (reset) begin
            slice_cnt   <= '0;
            col_cnt     <= '0;
            walk_active <= 1'b0;
        end else begin
            // readout throws away a partial block
            if (read_out || block_done) begin
                slice_cnt <= '0;
            end else if (take_beat) begin
                slice_cnt <= slice_cnt + 1'b1;
            end
            // a new block restarts the walk even on its final column
            if (block_done) begin
                walk_active <= 1'b1;
                col_cnt     <= '0;
            end else if (walk_active) begin
                if (last_col) begin
                    walk_active <= 1'b0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_beat) begin
            stage_trits[slice_cnt] <= trits;
            stage_act[slice_cnt]   <= activation;
        end
        // last beat bypasses staging straight into current
        if (block_done) begin
            for (int s = 0; s < `SLICES - 1; s++) begin
                cur_trits[s] <= stage_trits[s];
                cur_act[s]   <= stage_act[s];
            end
            cur_trits[`SLICES-1] <= trits;
            cur_act[`SLICES-1]   <= activation;
        end
    end

    // beat s feeds rows 5s .. 5s+4
    for (genvar s = 0; s < `SLICES; s++) begin : g_slice
        for (genvar k = 0; k < `TRITS_PER_BYTE; k++) begin : g_trit
            assign row_trits[s*`TRITS_PER_BYTE + k] = cur_trits[s][k];
        end
    end

    assign col_act   = cur_act[col_cnt];
    assign col_index = col_cnt;
    assign mac_en    = walk_active;
    assign busy      = walk_active;

endmodule

// ==== mac_array.sv ====
/*
 * accumulator grid, ROWS by SLICES cells
 * each row adds, subtracts or holds the walked activation per its trit
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module mac_array (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           read_out,
    input  logic                           mac_en,
    input  ternary_pkg::trit_t [`ROWS-1:0] row_trits,
    input  ternary_pkg::act_t              col_act,
    input  logic [`COL_W-1:0]              col_index,
    output ternary_pkg::acc_t              acc_grid [`ROWS*`SLICES]
);

    ternary_pkg::acc_t addend;

    // sign-extend the activation to accumulator width
    assign addend = ternary_pkg::acc_t'(col_act);

    for (genvar r = 0; r < `ROWS; r++) begin : g_row
        ternary_pkg::acc_t delta;

        // weight times activation, no multiplier needed
        always_comb begin
            case (row_trits[r])
                ternary_pkg::TRIT_POS: begin
                    delta = addend;
                end
                ternary_pkg::TRIT_NEG: begin
                    delta = -addend;
                end
                default: begin
                    delta = '0;
                end
            endcase
        end

        for (genvar c = 0; c < `SLICES; c++) begin : g_col
            ternary_pkg::acc_t acc;
            logic              hit;

            // only the walked column moves this cycle
            assign hit = mac_en && (int'(col_index) == c);

            always_ff @(posedge clk) begin
                // clear wins over a same-cycle update
                if (reset || read_out) begin
                    acc <= '0;
                end else if (hit) begin
                    // wraps silently at ACC_W bits
                    acc <= acc + delta;
                end
            end

            // row-major grid order
            assign acc_grid[r*`SLICES + c] = acc;
        end
    end

endmodule

// ==== readout_queue.sv ====
/*
 * readout shift queue
 * snapshots the grid on read_out, then streams bits 15..8 of each cell
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module readout_queue (
    input  logic              clk,
    input  logic              reset,
    input  logic              read_out,
    input  ternary_pkg::acc_t acc_grid [`ROWS*`SLICES],
    output logic              out_valid,
    output logic [`ACT_W-1:0] out_data
);

    localparam int ELEMS = `ROWS * `SLICES;
    localparam int CNT_W = $clog2(ELEMS + 1);

    ternary_pkg::rd_state_t state;
    logic [CNT_W-1:0]       remaining;
    ternary_pkg::acc_t      queue [ELEMS];

    // fsm with countdown of cells still to present
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ternary_pkg::RD_IDLE;
            remaining <= '0;
        end else if (read_out) begin
            // a second pulse restarts the stream from the top
            state     <= ternary_pkg::RD_STREAM;
            remaining <= CNT_W'(ELEMS);
        end else if (state == ternary_pkg::RD_STREAM) begin
            if (remaining == CNT_W'(1)) begin
                state <= ternary_pkg::RD_IDLE;
            end
            remaining <= remaining - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_out) begin
            // grid values from before the clear on this edge
            for (int i = 0; i < ELEMS; i++) begin
                queue[i] <= acc_grid[i];
            end
        end else if (state == ternary_pkg::RD_STREAM) begin
            // head leaves, rest move down one slot
            for (int i = 0; i < ELEMS - 1; i++) begin
                queue[i] <= queue[i+1];
            end
        end
    end

    assign out_valid = state == ternary_pkg::RD_STREAM;
    // drop the low fraction bits and the top wrap bit
    assign out_data  = queue[0][`OUT_SHIFT + `ACT_W - 1:`OUT_SHIFT];

endmodule

// ==== ternary_matmul_top.sv ====
/*
 * ternary matrix accumulator top level
 * decoder, operand buffer, mac grid and readout queue
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module ternary_matmul_top (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        weight_byte,
    input  ternary_pkg::act_t activation,
    input  logic              load,
    input  logic              read_out,
    output logic              busy,
    output logic              out_valid,
    output logic [`ACT_W-1:0] out_data
);

    ternary_pkg::trit_vec_t           trits;
    ternary_pkg::trit_t [`ROWS-1:0]   row_trits;
    ternary_pkg::act_t                col_act;
    logic [`COL_W-1:0]                col_index;
    logic                             mac_en;
    ternary_pkg::acc_t                acc_grid [`ROWS*`SLICES];

    ternary_unpack u_unpack (
        .weight_byte (weight_byte),
        .trits       (trits)
    );

    operand_buffer u_operand_buffer (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .read_out   (read_out),
        .trits      (trits),
        .activation (activation),
        .row_trits  (row_trits),
        .col_act    (col_act),
        .col_index  (col_index),
        .mac_en     (mac_en),
        .busy       (busy)
    );

    mac_array u_mac_array (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .mac_en    (mac_en),
        .row_trits (row_trits),
        .col_act   (col_act),
        .col_index (col_index),
        .acc_grid  (acc_grid)
    );

    readout_queue u_readout_queue (
        .clk       (clk),
        .reset     (reset),
        .read_out  (read_out),
        .acc_grid  (acc_grid),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== ternary_matmul_asserts.sv ====
/*
 * bound protocol checks for the ternary accumulator
 * read_out vs busy, stream length, state after reset
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module ternary_matmul_asserts (
    input logic clk,
    input logic reset,
    input logic read_out,
    input logic busy,
    input logic out_valid
);

    localparam int ELEMS = `ROWS * `SLICES;

    // length of the current out_valid run
    int run_len;

    always_ff @(posedge clk) begin
        if (reset || !out_valid) begin
            run_len <= 0;
        end else begin
            run_len <= run_len + 1;
        end
    end

    // no readout while a block is being walked
    readout_not_busy: assert property (@(posedge clk) disable iff (reset) read_out |-> !busy)
        else $error("read_out raised while busy");

    // stream starts right after the pulse
    stream_start: assert property (@(posedge clk) disable iff (reset) read_out |=> out_valid)
        else $error("out_valid did not rise after read_out");

    // one cell per cycle, ROWS x SLICES cycles
    stream_length: assert property (@(posedge clk) disable iff (reset)
        $fell(out_valid) |-> run_len == ELEMS)
        else $error("out_valid run length differs from grid size");

    reset_quiet: assert property (@(posedge clk) reset |=> !busy && !out_valid)
        else $error("busy or out_valid high after reset");

endmodule

bind ternary_matmul_top ternary_matmul_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .read_out  (read_out),
    .busy      (busy),
    .out_valid (out_valid)
);

// ==== tb_ternary_matmul.sv ====
/*
 * testbench for the ternary accumulator
 * clock, reset, random blocks, reference model and stream checks
 */
`timescale 1ns/100ps
`include "ternary_defs.svh"

module tb_ternary_matmul;

    localparam int ELEMS = `ROWS * `SLICES;

    logic              clk;
    logic              reset;
    logic [7:0]        weight_byte;
    ternary_pkg::act_t activation;
    logic              load;
    logic              read_out;
    logic              busy;
    logic              out_valid;
    logic [`ACT_W-1:0] out_data;

    // reference accumulators, wrapping at ACC_W like the grid
    ternary_pkg::acc_t model_acc [ELEMS];
    // beats of the block still being collected
    logic [7:0]        pend_byte [`SLICES];
    ternary_pkg::act_t pend_act  [`SLICES];
    int                pend_cnt;

    ternary_matmul_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .weight_byte (weight_byte),
        .activation  (activation),
        .load        (load),
        .read_out    (read_out),
        .busy        (busy),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

    always #10 clk = ~clk;

    task automatic abort_run(string what);
        $display("Simulation failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_out(string name, logic [`ACT_W-1:0] expected, logic [`ACT_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            abort_run("streamed value differs from the model");
        end
    endtask

    task automatic check_level(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %0b, actual %0b", name, expected, actual);
            abort_run("status level differs from the model");
        end
    endtask

    // weight k of a packed byte, base-3 digit k with 2 meaning -1
    function automatic int weight_of(logic [7:0] b, int k);
        int v;
        int d;
        v = int'(b);
        if (v > `MAX_PACKED) begin
            return 0;
        end
        for (int j = 0; j < k; j++) begin
            v = v / 3;
        end
        d = v % 3;
        if (d == 2) begin
            return -1;
        end
        return d;
    endfunction

    // record one beat, add the outer product once the block is whole
    task automatic model_beat(logic [7:0] b, ternary_pkg::act_t a);
        int w;
        int row;
        pend_byte[pend_cnt] = b;
        pend_act[pend_cnt]  = a;
        pend_cnt++;
        if (pend_cnt == `SLICES) begin
            for (int s = 0; s < `SLICES; s++) begin
                for (int k = 0; k < `TRITS_PER_BYTE; k++) begin
                    w   = weight_of(pend_byte[s], k);
                    row = s * `TRITS_PER_BYTE + k;
                    for (int c = 0; c < `SLICES; c++) begin
                        model_acc[row*`SLICES + c] = model_acc[row*`SLICES + c]
                            + ternary_pkg::acc_t'(w * int'(pend_act[c]));
                    end
                end
            end
            pend_cnt = 0;
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic send_beat(logic [7:0] b, ternary_pkg::act_t a);
        bit block_end;
        weight_byte = b;
        activation  = a;
        load        = 1'b1;
        model_beat(b, a);
        block_end = (pend_cnt == 0);
        @(negedge clk);
        load = 1'b0;
        // a completed block starts its walk on the next cycle
        if (block_end) begin
            check_level("busy after block", 1'b1, busy);
        end
    endtask

    task automatic send_block(bit valid_only, int max_gap);
        logic [7:0] b;
        for (int s = 0; s < `SLICES; s++) begin
            // optional idle cycles ahead of each beat
            if (max_gap > 0) begin
                repeat ($urandom_range(0, max_gap)) @(negedge clk);
            end
            b = valid_only ? 8'($urandom_range(0, `MAX_PACKED)) : 8'($urandom);
            send_beat(b, ternary_pkg::act_t'($urandom));
        end
    endtask

    // busy stays up for one cycle per column, then drops
    task automatic check_walk(string name);
        for (int c = 0; c < `SLICES; c++) begin
            check_level({name, " busy"}, 1'b1, busy);
            @(negedge clk);
        end
        check_level({name, " idle"}, 1'b0, busy);
    endtask

    task automatic wait_idle(int limit);
        int n;
        n = 0;
        while (busy) begin
            if (n == limit) begin
                abort_run("timeout: busy stayed high");
            end
            n++;
            @(negedge clk);
        end
    endtask

    // pulse read_out and compare the whole stream with the snapshot
    task automatic read_and_check(string name, bit overlap);
        logic [`ACT_W-1:0] exp_q [ELEMS];
        int                n;
        wait_idle(64);
        for (int i = 0; i < ELEMS; i++) begin
            exp_q[i]     = model_acc[i][`OUT_SHIFT + `ACT_W - 1:`OUT_SHIFT];
            model_acc[i] = '0;
        end
        // partial block is dropped, a load beside read_out is ignored
        pend_cnt    = 0;
        read_out    = 1'b1;
        load        = 1'b1;
        weight_byte = 8'($urandom);
        @(negedge clk);
        read_out = 1'b0;
        load     = 1'b0;
        n = 0;
        while (!out_valid) begin
            if (n == 8) begin
                abort_run("timeout: out_valid never rose after read_out");
            end
            n++;
            @(negedge clk);
        end
        for (int i = 0; i < ELEMS; i++) begin
            check_level({name, " out_valid"}, 1'b1, out_valid);
            check_out(name, exp_q[i], out_data);
            if (overlap && $urandom_range(0, 1) == 1) begin
                send_beat(8'($urandom), ternary_pkg::act_t'($urandom));
            end else begin
                @(negedge clk);
            end
        end
        check_level({name, " stream end"}, 1'b0, out_valid);
    endtask

    // back-to-back blocks of one weight pattern with large activations
    task automatic wrap_run(logic [7:0] b, int blocks);
        repeat (blocks * `SLICES) begin
            send_beat(b, ternary_pkg::act_t'($urandom_range(100, 127)));
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        weight_byte = '0;
        activation  = '0;
        load        = 1'b0;
        read_out    = 1'b0;
        pend_cnt    = 0;
        for (int i = 0; i < ELEMS; i++) begin
            model_acc[i] = '0;
        end
        void'($urandom(32'h914d_9648));
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        check_level("reset busy", 1'b0, busy);
        check_level("reset out_valid", 1'b0, out_valid);
        read_and_check("reset_zero", 1'b0);

        send_block(1'b1, 0);
        check_walk("single_block");
        read_and_check("single_block", 1'b0);

        // bytes above 242 included, random gaps in load
        repeat (40) send_block(1'b0, 3);
        wait_idle(`SLICES + 2);
        read_and_check("accumulate", 1'b0);

        repeat (3) send_block(1'b1, 1);
        repeat (`SLICES - 1) send_beat(8'($urandom), ternary_pkg::act_t'($urandom));
        read_and_check("partial_first", 1'b0);
        send_block(1'b1, 0);
        read_and_check("partial_next", 1'b0);

        repeat (5) send_block(1'b0, 2);
        read_and_check("overlap_stream", 1'b1);
        read_and_check("overlap_next", 1'b0);

        // 121 is all +1 digits, 242 is all -1 digits
        wrap_run(8'd121, 700);
        read_and_check("wrap_positive", 1'b0);
        wrap_run(8'd242, 700);
        read_and_check("wrap_negative", 1'b0);

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
ternary_pkg.sv
ternary_unpack.sv
operand_buffer.sv
mac_array.sv
readout_queue.sv
ternary_matmul_top.sv
ternary_matmul_asserts.sv
tb_ternary_matmul.sv

// ==== run.sh ====
#!/bin/sh
# compile the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ternary_matmul \
    -f vlog.f \
    -o sim_tb

# exit status of the simulation decides pass or fail
./obj_dir/sim_tb
